/* compile.f */
+incdir+verilog
verilog/display_pkg.sv
verilog/pixel_fifo_if.sv
verilog/display_regs.sv
verilog/pixel_fifo.sv
verilog/video_timing.sv
verilog/display_scanout.sv
verilog/mcd212_display.sv
sim/display_asserts.sv
sim/tb_mcd212_display.sv

/* sim/tb_mcd212_display.sv */
// Testbench with clock, reset, AXI4-Lite driver tasks, check task and directed display tests
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

module tb_mcd212_display;
    localparam int axi_limit   = 200;    // Cycles for one AXI handshake
    localparam int line_limit  = 4000;
    localparam int frame_limit = 600000;
    localparam int pixel_limit = 100000; // Longer than a vertical blank
    localparam logic [31:0] ctrl_enable = 32'h01;
    localparam logic [31:0] ctrl_fd     = 32'h02;
    localparam logic [31:0] ctrl_cm     = 32'h04;
    localparam logic [31:0] ctrl_cf     = 32'h10;

    logic                       clk;
    logic                       reset;
    logic [`DISPLAY_ADDR_W-1:0] s_axil_awaddr;
    logic                       s_axil_awvalid;
    logic                       s_axil_awready;
    logic [31:0]                s_axil_wdata;
    logic                       s_axil_wvalid;
    logic                       s_axil_wready;
    logic [1:0]                 s_axil_bresp;
    logic                       s_axil_bvalid;
    logic                       s_axil_bready;
    logic [`DISPLAY_ADDR_W-1:0] s_axil_araddr;
    logic                       s_axil_arvalid;
    logic                       s_axil_arready;
    logic [31:0]                s_axil_rdata;
    logic [1:0]                 s_axil_rresp;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;
    logic                       hsync;
    logic                       vsync;
    logic                       hblank;
    logic                       vblank;
    logic                       pixel_valid;
    logic [7:0]                 red;
    logic [7:0]                 green;
    logic [7:0]                 blue;
    string                      current_test;
    int                         seed;

    mcd212_display mcd212_display_i (.*);

    bind mcd212_display display_asserts asserts_i (
        .clk(clk), .reset(reset),
        .s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
        .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
        .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
        .s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
        .hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank),
        .pixel_valid(pixel_valid)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h",
                     current_test, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("ERROR [%s] gave up waiting for %s", current_test, what);
        $display("Test failures found");
        $fatal(1, "Stopped on a timeout");
    endtask

    // Offers address and data together and returns the edges up to the handshake
    task automatic axil_write(input logic [`DISPLAY_ADDR_W-1:0] addr, input logic [31:0] data,
                              input int limit, output logic [1:0] resp, output int cycles);
        int resp_cycles;
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wvalid  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) stop_on_timeout("write address and data handshake");
        end while (!(s_axil_awready && s_axil_wready));
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        resp_cycles = 0;
        do begin
            @(posedge clk);
            resp_cycles++;
            if (resp_cycles > axi_limit) stop_on_timeout("write response");
        end while (!s_axil_bvalid);
        resp = s_axil_bresp;
        s_axil_bready <= 1'b1; // Ready only after bvalid is seen
        @(posedge clk);
        s_axil_bready <= 1'b0;
    endtask

    task automatic write_reg(input logic [`DISPLAY_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        int         cycles;
        axil_write(addr, data, axi_limit, resp, cycles);
        check_value("write response", 32'h0, resp);
    endtask

    task automatic axil_read(input logic [`DISPLAY_ADDR_W-1:0] addr, output logic [31:0] data);
        int cycles;
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > axi_limit) stop_on_timeout("read address handshake");
        end while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > axi_limit) stop_on_timeout("read data");
        end while (!s_axil_rvalid);
        data = s_axil_rdata;
        check_value("read response", 32'h0, s_axil_rresp);
        s_axil_rready <= 1'b1; // Ready only after rvalid is seen
        @(posedge clk);
        s_axil_rready <= 1'b0;
    endtask

    task automatic wait_pixel();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > pixel_limit) stop_on_timeout("pixel_valid");
        end while (!pixel_valid);
    endtask

    task automatic wait_blank_rise(input logic vertical, input int limit);
        logic prev;
        logic now;
        int   cycles;
        cycles = 0;
        now = vertical ? vblank : hblank;
        do begin
            prev = now;
            @(posedge clk);
            now = vertical ? vblank : hblank;
            cycles++;
            if (cycles > limit) stop_on_timeout("a blanking rise");
        end while (!(now && !prev));
    endtask

    // Clocks up to the next hsync rise and whether vsync rose with it
    task automatic next_hsync_rise(output int clocks, output logic vsync_rose);
        logic prev_h;
        logic prev_v;
        clocks = 0;
        do begin
            prev_h = hsync;
            prev_v = vsync;
            @(posedge clk);
            clocks++;
            if (clocks > line_limit) stop_on_timeout("an hsync rise");
        end while (!(hsync && !prev_h));
        vsync_rose = vsync && !prev_v;
    endtask

    task automatic test_registers();
        logic [31:0] data;
        logic [1:0]  resp;
        int          cycles;
        current_test = "register access";
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("FIFO level after reset", 32'd0, data[15:8]);
        write_reg(`DISPLAY_REG_CTRL, 32'ha5a5_5a3e);
        axil_read(`DISPLAY_REG_CTRL, data);
        check_value("CTRL readback", 32'ha5a5_5a3e & 32'h3f, data);
        write_reg(`DISPLAY_REG_CTRL, 32'h0);
        axil_write(4'hc, 32'h1, axi_limit, resp, cycles);
        check_value("unmapped write response", 32'h2, resp);
    endtask

    task automatic test_line_mode(input logic [31:0] ctrl, input int line_clocks);
        int   clocks;
        int   lines;
        logic vrose;
        current_test = "line timing";
        write_reg(`DISPLAY_REG_CTRL, ctrl);
        next_hsync_rise(clocks, vrose); // Line around the mode switch can be odd
        next_hsync_rise(clocks, vrose);
        next_hsync_rise(clocks, vrose);
        check_value("clocks per line", line_clocks, clocks);
        lines = 0;
        do begin
            next_hsync_rise(clocks, vrose);
            lines++;
            if (lines > 600) stop_on_timeout("a vsync rise");
        end while (!vrose);
        lines = 0;
        do begin
            next_hsync_rise(clocks, vrose);
            lines++;
            if (lines > 600) stop_on_timeout("the next vsync rise");
        end while (!vrose);
        check_value("lines per frame", 32'd262, lines);
    endtask

    task automatic test_rgb_scanout();
        logic [15:0] words[$];
        logic [31:0] data;
        current_test = "RGB scanout";
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd);
        for (int i = 0; i < 20; i++) begin
            data = $urandom;
            words.push_back(data[15:0]); // Upper half must be dropped
            write_reg(`DISPLAY_REG_PIXEL, data);
        end
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("FIFO level before enable", 32'd20, data[15:8]);
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd | ctrl_enable);
        foreach (words[i]) begin
            wait_pixel();
            check_value("red", {words[i][14:10], words[i][14:12]}, red);
            check_value("green", {words[i][9:5], words[i][9:7]}, green);
            check_value("blue", {words[i][4:0], words[i][4:2]}, blue);
        end
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd);
    endtask

    task automatic test_grey_scanout();
        logic [15:0] words[$];
        logic [31:0] data;
        logic [7:0]  grey;
        current_test = "grey scanout";
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd | ctrl_cm);
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            words.push_back(data[15:0]);
            write_reg(`DISPLAY_REG_PIXEL, data);
        end
        wait_blank_rise(1'b0, line_limit); // Enable before the next line starts
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd | ctrl_cm | ctrl_enable);
        foreach (words[i]) begin
            for (int half = 0; half < 2; half++) begin
                grey = half ? words[i][15:8] : words[i][7:0];
                wait_pixel();
                check_value("grey red", grey, red);
                check_value("grey green", grey, green);
                check_value("grey blue", grey, blue);
            end
        end
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd);
    endtask

    task automatic test_underrun();
        logic [31:0] data;
        current_test = "underrun";
        write_reg(`DISPLAY_REG_STATUS, 32'h1);
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("underrun flag before enable", 32'd0, data[0]);
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd | ctrl_enable);
        repeat (4) begin
            wait_pixel();
            check_value("black pixel", 32'h0, {red, green, blue});
        end
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd);
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("underrun flag set", 32'd1, data[0]);
        write_reg(`DISPLAY_REG_STATUS, 32'h1);
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("underrun flag cleared", 32'd0, data[0]);
    endtask

    task automatic test_backpressure();
        logic [31:0] data;
        logic [1:0]  resp;
        int          cycles;
        current_test = "back-pressure";
        for (int i = 0; i < `DISPLAY_FIFO_DEPTH; i++) begin
            write_reg(`DISPLAY_REG_PIXEL, $urandom);
        end
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("FIFO level when full", `DISPLAY_FIFO_DEPTH, data[15:8]);
        // FIFO holds for many lines when enabled at the top of vertical blank
        wait_blank_rise(1'b1, frame_limit);
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd | ctrl_enable);
        axil_write(`DISPLAY_REG_PIXEL, $urandom, pixel_limit, resp, cycles);
        check_value("write held for 100 cycles", 32'd1, cycles > 100);
        check_value("stalled write response", 32'h0, resp);
        axil_read(`DISPLAY_REG_STATUS, data);
        check_value("level within depth", 32'd1, data[15:8] <= `DISPLAY_FIFO_DEPTH);
        write_reg(`DISPLAY_REG_CTRL, ctrl_fd);
    endtask

    initial begin
        seed = 32'h3b6c_8a52;
        void'($urandom(seed));
        clk            = 1'b0;
        reset          = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        current_test   = "reset";
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_registers();
        test_line_mode(ctrl_fd, 1792);
        test_line_mode(ctrl_fd | ctrl_cf, 1920);
        test_rgb_scanout();
        test_grey_scanout();
        test_underrun();
        test_backpressure();
        if (mcd212_display_i.asserts_i.error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "Assertion failures during the run");
        end
    end

endmodule

`default_nettype wire

/* sim/display_asserts.sv */
// Concurrent assertions on the AXI4-Lite handshakes and video timing of the display top
`timescale 1ns/1ps
`default_nettype none

module display_asserts (
    input wire clk,
    input wire reset,
    input wire s_axil_awvalid,
    input wire s_axil_awready,
    input wire s_axil_wvalid,
    input wire s_axil_wready,
    input wire s_axil_bvalid,
    input wire s_axil_bready,
    input wire s_axil_arvalid,
    input wire s_axil_arready,
    input wire s_axil_rvalid,
    input wire s_axil_rready,
    input wire hsync,
    input wire vsync,
    input wire hblank,
    input wire vblank,
    input wire pixel_valid
);
    int error_count = 0; // Assertion failures so far

    task automatic flag_failure(input string what);
        error_count++;
        $error("%s", what);
    endtask

    property valid_held(valid, ready);
        @(posedge clk) disable iff (reset) valid && !ready |=> valid;
    endproperty

    aw_held: assert property (valid_held(s_axil_awvalid, s_axil_awready))
        else flag_failure("awvalid dropped before awready");
    w_held: assert property (valid_held(s_axil_wvalid, s_axil_wready))
        else flag_failure("wvalid dropped before wready");
    b_held: assert property (valid_held(s_axil_bvalid, s_axil_bready))
        else flag_failure("bvalid dropped before bready");
    ar_held: assert property (valid_held(s_axil_arvalid, s_axil_arready))
        else flag_failure("arvalid dropped before arready");
    r_held: assert property (valid_held(s_axil_rvalid, s_axil_rready))
        else flag_failure("rvalid dropped before rready");

    // Pixels only inside the active area
    pixel_in_active: assert property (
        @(posedge clk) disable iff (reset) pixel_valid |-> !hblank && !vblank)
        else flag_failure("pixel_valid during blanking");

    // vsync edges land only on an hsync rise
    vsync_on_line: assert property (
        @(posedge clk) disable iff (reset) $changed(vsync) |-> $rose(hsync))
        else flag_failure("vsync changed away from an hsync rise");

endmodule

`default_nettype wire

/* verilog/mcd212_display.sv */
// Display subsystem top with AXI4-Lite slave ports and video outputs
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

module mcd212_display (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [`DISPLAY_ADDR_W-1:0] s_axil_awaddr,
    input  wire                       s_axil_awvalid,
    output logic                      s_axil_awready,
    input  wire [31:0]                s_axil_wdata,
    input  wire                       s_axil_wvalid,
    output logic                      s_axil_wready,
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  wire                       s_axil_bready,
    input  wire [`DISPLAY_ADDR_W-1:0] s_axil_araddr,
    input  wire                       s_axil_arvalid,
    output logic                      s_axil_arready,
    output logic [31:0]               s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  wire                       s_axil_rready,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblank,
    output logic                      vblank,
    output logic                      pixel_valid,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue
);
    logic enable;
    logic cf;
    logic st;
    logic cm;
    logic fd;
    logic underrun;

    pixel_fifo_if fifo_if ();

    display_regs regs_i (
        .clk(clk), .reset(reset),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata(s_axil_wdata), .s_axil_wvalid(s_axil_wvalid),
        .s_axil_wready(s_axil_wready),
        .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
        .fifo(fifo_if.writer),
        .enable(enable), .sm(), .cf(cf), .st(st), .cm(cm), .fd(fd), // Scan mode unused
        .vblank(vblank), .underrun(underrun)
    );

    pixel_fifo fifo_i (.clk(clk), .reset(reset), .fifo(fifo_if.fifo));

    display_scanout scanout_i (
        .clk(clk), .reset(reset),
        .enable(enable), .cf(cf), .st(st), .cm(cm), .fd(fd),
        .fifo(fifo_if.reader),
        .hsync(hsync), .vsync(vsync), .hblank(hblank), .vblank(vblank),
        .pixel_valid(pixel_valid), .red(red), .green(green), .blue(blue),
        .underrun(underrun)
    );

endmodule

`default_nettype wire

/* verilog/display_scanout.sv */
// Scanout that pops pixel words, decodes them by colour mode and drives video out
`timescale 1ns/1ps
`default_nettype none

module display_scanout (
    input  wire          clk,
    input  wire          reset,
    input  wire          enable,
    input  wire          cf,
    input  wire          st,
    input  wire          cm,
    input  wire          fd,
    pixel_fifo_if.reader fifo,
    output logic         hsync,
    output logic         vsync,
    output logic         hblank,
    output logic         vblank,
    output logic         pixel_valid,
    output logic [7:0]   red,
    output logic [7:0]   green,
    output logic [7:0]   blue,
    output logic         underrun
);
    import display_pkg::*;

    logic        t_hsync;
    logic        t_vsync;
    logic        t_hblank;
    logic        t_vblank;
    logic        new_line;
    logic        new_pixel;
    logic        take;
    logic        phase; // High when the grey high byte is next
    pixel_word_u head;
    logic [7:0]  grey_byte;

    video_timing timing_i (
        .clk(clk), .reset(reset), .cf(cf), .st(st), .fd(fd),
        .hsync(t_hsync), .vsync(t_vsync), .hblank(t_hblank), .vblank(t_vblank),
        .new_line(new_line), .new_pixel(new_pixel), .cm(cm)
    );

    assign head        = fifo.rd_data;
    assign take        = new_pixel && enable; // new_pixel is only set in the active area
    assign fifo.rd_en  = take && (!cm || phase);
    assign grey_byte   = phase ? head.grey.second : head.grey.first;

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
            underrun    <= 1'b0;
            phase       <= 1'b0;
            {hsync, vsync, hblank, vblank} <= '0;
        end else begin
            pixel_valid <= take;
            underrun    <= take && fifo.empty;
            if (new_line) begin
                phase <= 1'b0;
            end else if (take && cm && !fifo.empty) begin
                phase <= !phase;
            end
            // Aligned with the pixel register
            {hsync, vsync, hblank, vblank} <= {t_hsync, t_vsync, t_hblank, t_vblank};
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (fifo.empty) begin
                {red, green, blue} <= '0; // Black on underrun
            end else if (cm) begin
                {red, green, blue} <= {3{grey_byte}};
            end else begin
                red   <= expand5(head.rgb.red);
                green <= expand5(head.rgb.green);
                blue  <= expand5(head.rgb.blue);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/video_timing.sv */
// MCD212 video timing generator with sync, blank, line and pixel strobes
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

module video_timing (
    input  wire  clk,
    input  wire  reset,
    input  wire  cf,  // 0 = 28 MHz crystal, 1 = 30 MHz
    input  wire  st,  // 1 = 360/720 pixel lines
    input  wire  fd,  // 0 = 50 Hz, 1 = 60 Hz
    output logic hsync,
    output logic vsync,
    output logic hblank,
    output logic vblank,
    output logic new_line,
    output logic new_pixel,
    input  wire  cm   // 0 = 4 clocks per pixel, 1 = 2
);
    localparam logic [8:0] v_sync = 9'd3;

    logic [6:0]  h_total_cyc;
    logic [6:0]  h_active_cyc;
    logic [6:0]  h_start_cyc;
    logic [6:0]  h_sync_cyc;
    logic [10:0] h_total;
    logic [10:0] h_active;
    logic [10:0] h_start;
    logic [10:0] h_sync;
    logic [8:0]  v_total;
    logic [8:0]  v_active;
    logic [8:0]  v_start;
    logic [10:0] video_x;
    logic [8:0]  video_y;
    logic        in_h;
    logic        in_v;

    // Horizontal totals from datasheet table 5-4 in timing units
    always_comb begin
        if (st && cf) begin
            h_total_cyc = 7'd120;
            h_active_cyc = 7'd90;
            h_start_cyc = 7'd23;
            h_sync_cyc = 7'd9;
        end else if (cf) begin
            h_total_cyc = 7'd120;
            h_active_cyc = 7'd96;
            h_start_cyc = 7'd20;
            h_sync_cyc = 7'd9;
        end else begin
            h_total_cyc = 7'd112;
            h_active_cyc = 7'd90;
            h_start_cyc = 7'd19;
            h_sync_cyc = 7'd8;
        end
    end

    assign h_total  = 11'(h_total_cyc * `DISPLAY_CLKS_PER_CYCLE);
    assign h_active = 11'(h_active_cyc * `DISPLAY_CLKS_PER_CYCLE);
    assign h_start  = 11'(h_start_cyc * `DISPLAY_CLKS_PER_CYCLE);
    assign h_sync   = 11'(h_sync_cyc * `DISPLAY_CLKS_PER_CYCLE);

    // Vertical totals from datasheet table 5-6 in lines
    always_comb begin
        if (fd) begin
            v_total = 9'd262; // NTSC
            v_active = 9'd240;
            v_start = 9'd18;
        end else if (st) begin
            v_total = 9'd312; // PAL with NTSC height
            v_active = 9'd240;
            v_start = 9'd46;
        end else begin
            v_total = 9'd312;
            v_active = 9'd280;
            v_start = 9'd26;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            video_x <= '0;
            video_y <= '0;
        end else if (video_x == h_total - 1'b1) begin // End of line
            video_x <= '0;
            video_y <= (video_y == v_total - 1'b1) ? '0 : video_y + 1'b1;
        end else begin
            video_x <= video_x + 1'b1;
        end
    end

    assign in_h = video_x >= h_start && video_x < h_start + h_active;
    assign in_v = video_y >= v_start && video_y < v_start + v_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            hblank    <= 1'b0;
            vblank    <= 1'b0;
            new_line  <= 1'b0;
            new_pixel <= 1'b0;
        end else begin
            hsync     <= video_x < h_sync;
            vsync     <= video_y < v_sync;
            hblank    <= !in_h;
            vblank    <= !in_v;
            new_line  <= video_x == '0;
            new_pixel <= in_h && in_v && (cm ? video_x[0] : video_x[1:0] == 2'd1);
        end
    end

endmodule

`default_nettype wire

/* verilog/pixel_fifo.sv */
// Synchronous pixel word FIFO with full, empty and level
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

module pixel_fifo (
    input  wire       clk,
    input  wire       reset,
    pixel_fifo_if.fifo fifo
);
    import display_pkg::*;

    localparam int depth   = `DISPLAY_FIFO_DEPTH;
    localparam int ptr_w   = $clog2(depth);
    localparam int level_w = $clog2(depth + 1);

    pixel_word_u        mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr; // Wraps naturally since depth is a power of two
    logic [level_w-1:0] count;
    logic               push;
    logic               pop;

    assign push = fifo.wr_en && !fifo.full;
    assign pop  = fifo.rd_en && !fifo.empty; // Pop on empty is dropped

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fifo.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    assign fifo.rd_data = mem[rd_ptr];
    assign fifo.full    = count == level_w'(depth);
    assign fifo.empty   = count == '0;
    assign fifo.level   = count;

endmodule

`default_nettype wire

/* verilog/display_regs.sv */
// AXI4-Lite register block with CTRL, STATUS and the PIXEL push port
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

module display_regs (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [`DISPLAY_ADDR_W-1:0]   s_axil_awaddr,
    input  wire                         s_axil_awvalid,
    output logic                        s_axil_awready,
    input  wire [31:0]                  s_axil_wdata,
    input  wire                         s_axil_wvalid,
    output logic                        s_axil_wready,
    output logic [1:0]                  s_axil_bresp,
    output logic                        s_axil_bvalid,
    input  wire                         s_axil_bready,
    input  wire [`DISPLAY_ADDR_W-1:0]   s_axil_araddr,
    input  wire                         s_axil_arvalid,
    output logic                        s_axil_arready,
    output logic [31:0]                 s_axil_rdata,
    output logic [1:0]                  s_axil_rresp,
    output logic                        s_axil_rvalid,
    input  wire                         s_axil_rready,
    pixel_fifo_if.writer                fifo,
    output logic                        enable,
    output logic                        sm,
    output logic                        cf,
    output logic                        st,
    output logic                        cm,
    output logic                        fd,
    input  wire                         vblank,
    input  wire                         underrun
);
    import display_pkg::*;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic [5:0] ctrl;
    logic       underrun_flag;
    logic       wr_is_pixel;
    logic       wr_take;
    logic       rd_take;

    assign wr_is_pixel = s_axil_awaddr == `DISPLAY_REG_PIXEL;
    // Address and data accepted together and held off while a PIXEL write meets a full FIFO
    assign wr_take = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid
                     && !(wr_is_pixel && fifo.full);
    assign s_axil_awready = wr_take;
    assign s_axil_wready  = wr_take;
    assign rd_take        = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = rd_take;

    assign fifo.wr_en   = wr_take && wr_is_pixel; // Push in the handshake cycle
    assign fifo.wr_data = pixel_word_u'(s_axil_wdata[15:0]);

    assign enable = ctrl[0];
    assign fd     = ctrl[1];
    assign cm     = ctrl[2];
    assign st     = ctrl[3];
    assign cf     = ctrl[4];
    assign sm     = ctrl[5]; // Stored only

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl          <= '0;
            underrun_flag <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (s_axil_rvalid && s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
            if (wr_take) begin
                s_axil_bvalid <= 1'b1;
                if (s_axil_awaddr == `DISPLAY_REG_CTRL) begin
                    ctrl <= s_axil_wdata[5:0];
                end
                if (s_axil_awaddr == `DISPLAY_REG_STATUS && s_axil_wdata[0]) begin
                    underrun_flag <= 1'b0; // Write 1 to clear
                end
            end
            if (underrun) begin
                underrun_flag <= 1'b1; // New event wins over a clear
            end
            if (rd_take) begin
                s_axil_rvalid <= 1'b1;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wr_take) begin
            case (s_axil_awaddr)
                `DISPLAY_REG_CTRL, `DISPLAY_REG_STATUS, `DISPLAY_REG_PIXEL:
                    s_axil_bresp <= resp_okay;
                default: s_axil_bresp <= resp_slverr;
            endcase
        end
        if (rd_take) begin
            s_axil_rresp <= resp_okay;
            case (s_axil_araddr)
                `DISPLAY_REG_CTRL:   s_axil_rdata <= {26'h0, ctrl};
                `DISPLAY_REG_STATUS: s_axil_rdata <= {16'h0, 8'(fifo.level), 6'h0,
                                                      vblank, underrun_flag};
                `DISPLAY_REG_PIXEL:  s_axil_rdata <= 32'h0; // Write-only
                default: begin
                    s_axil_rdata <= 32'h0;
                    s_axil_rresp <= resp_slverr;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/pixel_fifo_if.sv */
// Pixel FIFO interface with writer, fifo and reader modports
`timescale 1ns/1ps
`default_nettype none
`include "display_cfg.svh"

interface pixel_fifo_if;
    import display_pkg::*;

    localparam int level_w = $clog2(`DISPLAY_FIFO_DEPTH + 1);

    logic               wr_en;
    pixel_word_u        wr_data;
    logic               full;
    logic               rd_en;
    pixel_word_u        rd_data; // Head word while not empty
    logic               empty;
    logic [level_w-1:0] level;

    modport writer (output wr_en, wr_data, input full, level);
    modport fifo   (input wr_en, wr_data, rd_en, output full, rd_data, empty, level);
    modport reader (output rd_en, input rd_data, empty);

endinterface

`default_nettype wire

/* verilog/display_pkg.sv */
// Pixel word union with its RGB555 and grey pair views, channel expansion function
`default_nettype none

package display_pkg;

    // 4-clocks-per-pixel word holding one RGB555 pixel
    typedef struct packed {
        logic       unused;
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb555_t;

    // 2-clocks-per-pixel word holding two grey pixels
    typedef struct packed {
        logic [7:0] second; // Shown after the low byte
        logic [7:0] first;
    } pixel_pair_t;

    typedef union packed {
        rgb555_t     rgb;
        pixel_pair_t grey;
    } pixel_word_u;

    // Top bits repeated below so full scale maps to 0xff
    function automatic logic [7:0] expand5(input logic [4:0] channel);
        return {channel, channel[4:2]};
    endfunction

endpackage

`default_nettype wire

/* verilog/display_cfg.svh */
// FIFO depth, AXI4-Lite address width, timing unit length and register offsets
`ifndef DISPLAY_CFG_SVH
`define DISPLAY_CFG_SVH

// Pixel words held by the FIFO as a power of two
`define DISPLAY_FIFO_DEPTH 32

`define DISPLAY_ADDR_W 4

// Clocks per datasheet timing unit
`define DISPLAY_CLKS_PER_CYCLE 16

`define DISPLAY_REG_CTRL   'h0
`define DISPLAY_REG_STATUS 'h4
`define DISPLAY_REG_PIXEL  'h8

`endif
